/* include/predictor_consts.svh */
// Branch predictor sizing constants
// Reset PC and RISC-V opcodes used by fetch and resolution

`ifndef PREDICTOR_CONSTS_SVH
`define PREDICTOR_CONSTS_SVH

// BTB depth, direct mapped
`define BTB_ENTRIES 32

// Global history width, also the PHT index width
`define GHR_BITS 5

// Fetch address after reset
`define PC_START 32'h0000_0000

// Conditional branch group (beq, bne, ...)
`define OP_BRANCH 7'b1100011

// Unconditional jumps
`define OP_JAL  7'b1101111
`define OP_JALR 7'b1100111

`endif

/* verilog/predictorPkg.sv */
// Shared types of the fetch branch predictor
// Address and index vectors, counter states, resolution record

`include "predictor_consts.svh"

package predictorPkg;

    // Instruction address and opcode
    typedef logic [31:0] addrT;
    typedef logic [6:0]  opcodeT;

    // BTB index comes from PC[6:2], tag is everything above it
    typedef logic [$clog2(`BTB_ENTRIES)-1:0]      btbIdxT;
    typedef logic [31-$clog2(`BTB_ENTRIES)-2:0]   btbTagT;

    // Gshare index, same width as the history
    typedef logic [`GHR_BITS-1:0] phtIdxT;

    // 2-bit saturating counter
    typedef enum logic [1:0] {
        strongNot   = 2'b00,
        weakNot     = 2'b01,
        weakTaken   = 2'b10,
        strongTaken = 2'b11
    } ctrStateT;

    // Outcome of one branch or jump as seen by execute
    typedef struct packed {
        logic   valid;
        addrT   pc;
        logic   isBranch;
        logic   isJump;
        logic   taken;
        addrT   target;
        logic   predTaken;   // what fetch guessed
        phtIdxT phtIdx;      // index fetch used, returned for the update
    } resolveT;

endpackage

/* verilog/targetBuffer.sv */
// Direct-mapped branch target buffer
// Tag compare lookup for the fetch PC, write port for resolved branches

`timescale 1ns/1ps
`include "predictor_consts.svh"

module targetBuffer
    import predictorPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  addrT    pc_i,
    output logic    hit_o,
    output logic    isJump_o,
    output addrT    target_o,
    input  logic    we_i,
    input  resolveT resolve_i
);

    localparam int IdxBits = $clog2(`BTB_ENTRIES);

    btbIdxT rdIdx;
    btbTagT rdTag;
    btbIdxT wrIdx;
    btbTagT wrTag;

    // Per-entry state
    logic   entryValid [`BTB_ENTRIES];
    btbTagT tagMem     [`BTB_ENTRIES];
    addrT   targetMem  [`BTB_ENTRIES];
    logic   jumpMem    [`BTB_ENTRIES];

    // Word address bits select the entry
    assign rdIdx = pc_i[IdxBits+1:2];
    assign rdTag = pc_i[31:IdxBits+2];
    assign wrIdx = resolve_i.pc[IdxBits+1:2];
    assign wrTag = resolve_i.pc[31:IdxBits+2];

    // Zero-cycle lookup
    assign hit_o    = entryValid[rdIdx] && (tagMem[rdIdx] == rdTag);
    assign isJump_o = jumpMem[rdIdx];
    assign target_o = targetMem[rdIdx];

    // Valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (we_i) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    // Payload written alongside the valid bit
    always_ff @(posedge clk) begin
        if (we_i) begin
            tagMem[wrIdx]    <= wrTag;
            targetMem[wrIdx] <= resolve_i.target;
            jumpMem[wrIdx]   <= resolve_i.isJump;
        end
    end

endmodule

/* verilog/gsharePht.sv */
// Gshare direction predictor
// Global history register, XOR index and table of 2-bit counters

`timescale 1ns/1ps
`include "predictor_consts.svh"

module gsharePht
    import predictorPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  addrT   pc_i,
    input  logic   hit_i,
    input  logic   isJump_i,
    input  logic   shift_i,
    input  logic   clear_i,
    input  logic   we_i,
    input  logic   inc_i,
    input  phtIdxT updIdx_i,
    output logic   predTaken_o,
    output phtIdxT phtIdx_o
);

    localparam int PhtEntries = 1 << `GHR_BITS;

    phtIdxT   ghr;
    ctrStateT phtMem [PhtEntries];
    ctrStateT curCtr;
    ctrStateT nextCtr;

    // PC word bits folded with history
    assign phtIdx_o = pc_i[`GHR_BITS+1:2] ^ ghr;

    // Jumps always go, branches follow the counter MSB, misses fall through
    assign predTaken_o = hit_i && (isJump_i || phtMem[phtIdx_o][1]);

    assign curCtr = phtMem[updIdx_i];

    // Saturating step
    always_comb begin
        nextCtr = curCtr;
        case (curCtr)
            strongNot:   nextCtr = inc_i ? weakNot     : strongNot;
            weakNot:     nextCtr = inc_i ? weakTaken   : strongNot;
            weakTaken:   nextCtr = inc_i ? strongTaken : weakNot;
            strongTaken: nextCtr = inc_i ? strongTaken : weakTaken;
            default:     nextCtr = weakNot;
        endcase
    end

    // Clear on mispredict beats the speculative shift
    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (clear_i) begin
            ghr <= '0;
        end else if (shift_i) begin
            ghr <= {ghr[`GHR_BITS-2:0], predTaken_o};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                phtMem[i] <= weakNot;
            end
        end else if (we_i) begin
            phtMem[updIdx_i] <= nextCtr;
        end
    end

    // A counter update needs a known index and direction
    phtWriteKnownAssert : assert property (
        @(posedge clk) disable iff (reset) we_i |-> !$isunknown({inc_i, updIdx_i})
    );

endmodule

/* verilog/predictControl.sv */
// Execute-side resolution control
// Mispredict detection, redirect address and table write enables

`timescale 1ns/1ps

module predictControl
    import predictorPkg::*;
(
    input  resolveT resolve_i,
    output logic    mispredict_o,
    output addrT    redirectPc_o,
    output logic    btbWe_o,
    output logic    phtWe_o,
    output logic    phtInc_o
);

    logic branchWrong;
    logic jumpWrong;

    // Branch guessed the wrong direction
    assign branchWrong = resolve_i.isBranch && (resolve_i.predTaken != resolve_i.taken);

    // Jump that fetch did not follow
    assign jumpWrong = resolve_i.isJump && !resolve_i.predTaken;

    assign mispredict_o = resolve_i.valid && (branchWrong || jumpWrong);

    // Undo a taken guess with pc+4, otherwise go to the real target
    assign redirectPc_o = resolve_i.predTaken ? (resolve_i.pc + 32'd4) : resolve_i.target;

    // BTB learns taken branches and all jumps
    assign btbWe_o = resolve_i.valid
                   && ((resolve_i.isBranch && resolve_i.taken) || resolve_i.isJump);

    // Counters only train on conditional branches
    assign phtWe_o  = resolve_i.valid && resolve_i.isBranch;
    assign phtInc_o = resolve_i.taken;

    // A resolved instruction is a branch or a jump, never both
    always_comb begin
        if (resolve_i.valid) begin
            assert (!(resolve_i.isBranch && resolve_i.isJump))
                else $error("predictControl: resolution marked as both branch and jump");
        end
    end

endmodule

/* verilog/fetchPc.sv */
// Fetch program counter
// Next-PC priority of redirect, stall, predicted target and pc+4

`timescale 1ns/1ps
`include "predictor_consts.svh"

module fetchPc
    import predictorPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic stall_i,
    input  logic predTaken_i,
    input  addrT target_i,
    input  logic redirect_i,
    input  addrT redirectPc_i,
    output addrT pc_o
);

    addrT pcNext;

    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;     // execute overrides a stall
        end else if (stall_i) begin
            pcNext = pc_o;
        end else if (predTaken_i) begin
            pcNext = target_i;
        end else begin
            pcNext = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= `PC_START;
        end else begin
            pc_o <= pcNext;
        end
    end

    // Targets from the BTB and redirects from execute keep alignment
    pcAlignAssert : assert property (
        @(posedge clk) disable iff (reset) pc_o[1:0] == 2'b00
    );

endmodule

/* verilog/fetchPredictor.sv */
// Fetch-side branch prediction unit, top level
// Wires resolution control, BTB, gshare table and fetch PC together

`timescale 1ns/1ps
`include "predictor_consts.svh"

module fetchPredictor
    import predictorPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stall_i,
    input  opcodeT  fetchOp_i,
    input  resolveT resolve_i,
    output addrT    pcF_o,
    output logic    predTaken_o,
    output phtIdxT  phtIdx_o,
    output logic    mispredict_o
);

    // Resolution side
    addrT redirectPc;
    logic btbWe;
    logic phtWe;
    logic phtInc;

    // Fetch side lookup
    logic btbHit;
    logic btbIsJump;
    addrT btbTarget;

    predictControl i_predictControl (
        .resolve_i    (resolve_i),
        .mispredict_o (mispredict_o),
        .redirectPc_o (redirectPc),
        .btbWe_o      (btbWe),
        .phtWe_o      (phtWe),
        .phtInc_o     (phtInc)
    );

    targetBuffer i_targetBuffer (
        .clk       (clk),
        .reset     (reset),
        .pc_i      (pcF_o),
        .hit_o     (btbHit),
        .isJump_o  (btbIsJump),
        .target_o  (btbTarget),
        .we_i      (btbWe),
        .resolve_i (resolve_i)
    );

    // History shifts only for branches actually fetched this cycle
    gsharePht i_gsharePht (
        .clk         (clk),
        .reset       (reset),
        .pc_i        (pcF_o),
        .hit_i       (btbHit),
        .isJump_i    (btbIsJump),
        .shift_i     (!stall_i && (fetchOp_i == `OP_BRANCH)),
        .clear_i     (mispredict_o),
        .we_i        (phtWe),
        .inc_i       (phtInc),
        .updIdx_i    (resolve_i.phtIdx),
        .predTaken_o (predTaken_o),
        .phtIdx_o    (phtIdx_o)
    );

    fetchPc i_fetchPc (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall_i),
        .predTaken_i  (predTaken_o),
        .target_i     (btbTarget),
        .redirect_i   (mispredict_o),
        .redirectPc_i (redirectPc),
        .pc_o         (pcF_o)
    );

endmodule

/* bench/predictorChecker.sv */
// Reference model of the fetch predictor
// Per-cycle comparison of the DUT outputs against the model

`timescale 1ns/1ps
`include "predictor_consts.svh"

module predictorChecker
    import predictorPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stall_i,
    input  opcodeT  fetchOp_i,
    input  resolveT resolve_i,
    input  addrT    pcF_i,
    input  logic    predTaken_i,
    input  phtIdxT  phtIdx_i,
    input  logic    mispredict_i,
    output int      errCount_o
);

    int errCount = 0;

    // Model state
    addrT       pc;
    phtIdxT     ghr;
    logic       btbValid  [`BTB_ENTRIES];
    btbTagT     btbTag    [`BTB_ENTRIES];
    addrT       btbTarget [`BTB_ENTRIES];
    logic       btbJump   [`BTB_ENTRIES];
    logic [1:0] ctr       [1 << `GHR_BITS];

    assign errCount_o = errCount;

    task automatic compare(input string name, input logic [31:0] dut, input logic [31:0] model);
        if (dut !== model) begin
            $display("** Error: %s dut=%h model=%h at %0t", name, dut, model, $time);
            errCount++;
        end
    endtask

    // Outputs are stable at the rising edge, inputs were driven half a cycle earlier
    always @(posedge clk) begin
        btbIdxT idx;
        btbIdxT wrIdx;
        phtIdxT gIdx;
        logic   hit;
        logic   pred;
        logic   wrong;
        addrT   redirect;
        if (reset) begin
            pc = `PC_START;
            ghr = '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                btbValid[i] = 1'b0;
            end
            for (int i = 0; i < (1 << `GHR_BITS); i++) begin
                ctr[i] = 2'd1;
            end
        end else begin
            idx = pc[6:2];
            hit = btbValid[idx] && (btbTag[idx] == pc[31:7]);
            gIdx = pc[6:2] ^ ghr;
            pred = hit && (btbJump[idx] || (ctr[gIdx] >= 2'd2));
            wrong = resolve_i.valid
                  && ((resolve_i.isBranch && (resolve_i.predTaken != resolve_i.taken))
                      || (resolve_i.isJump && !resolve_i.predTaken));
            redirect = resolve_i.predTaken ? (resolve_i.pc + 32'd4) : resolve_i.target;

            compare("pcF_o", pcF_i, pc);
            compare("predTaken_o", 32'(predTaken_i), 32'(pred));
            compare("phtIdx_o", 32'(phtIdx_i), 32'(gIdx));
            compare("mispredict_o", 32'(mispredict_i), 32'(wrong));

            // History and next PC from the tables as they were this cycle
            if (wrong) begin
                ghr = '0;
            end else if (!stall_i && (fetchOp_i == `OP_BRANCH)) begin
                ghr = {ghr[`GHR_BITS-2:0], pred};
            end
            if (wrong) begin
                pc = redirect;
            end else if (stall_i) begin
                pc = pc;
            end else if (pred) begin
                pc = btbTarget[idx];
            end else begin
                pc = pc + 32'd4;
            end

            // Table training from the resolved instruction
            wrIdx = resolve_i.pc[6:2];
            if (resolve_i.valid
                && ((resolve_i.isBranch && resolve_i.taken) || resolve_i.isJump)) begin
                btbValid[wrIdx] = 1'b1;
                btbTag[wrIdx] = resolve_i.pc[31:7];
                btbTarget[wrIdx] = resolve_i.target;
                btbJump[wrIdx] = resolve_i.isJump;
            end
            if (resolve_i.valid && resolve_i.isBranch) begin
                if (resolve_i.taken && (ctr[resolve_i.phtIdx] != 2'd3)) begin
                    ctr[resolve_i.phtIdx] = ctr[resolve_i.phtIdx] + 2'd1;
                end else if (!resolve_i.taken && (ctr[resolve_i.phtIdx] != 2'd0)) begin
                    ctr[resolve_i.phtIdx] = ctr[resolve_i.phtIdx] - 2'd1;
                end
            end
        end
    end

endmodule

/* bench/fetchPredictorTb.sv */
// Testbench top for the fetch branch predictor
// Clock, reset, directed and seeded random stimulus, watchdog and summary

`timescale 1ns/1ps
`include "predictor_consts.svh"

module fetchPredictorTb
    import predictorPkg::*;
();

    localparam int RandomCycles = 2000;
    localparam int TotalCycles  = RandomCycles + 100;
    localparam opcodeT OpNop    = 7'h13;

    // Counter training outcomes and the prediction expected after each
    localparam logic [8:0] TrainTaken = 9'b001111000;
    localparam logic [8:0] TrainPred  = 9'b011110000;

    // One fetched instruction waiting for execute
    typedef struct packed {
        addrT   pc;
        opcodeT op;
        logic   pred;
        phtIdxT idx;
    } fetchRecT;

    logic     clk = 1'b0;
    logic     reset;
    logic     stall;
    opcodeT   fetchOp;
    resolveT  resolve;
    addrT     pcF;
    logic     predTaken;
    phtIdxT   phtIdx;
    logic     mispredict;
    integer   seed = 32'h79e4;
    int       tbErrors = 0;
    int       checkerErrors;
    int       testsRun = 0;
    int       testsFailed = 0;
    int       errorsAtStart = 0;
    fetchRecT inflight [$];

    always #2 clk = ~clk;

    fetchPredictor i_fetchPredictor (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall),
        .fetchOp_i    (fetchOp),
        .resolve_i    (resolve),
        .pcF_o        (pcF),
        .predTaken_o  (predTaken),
        .phtIdx_o     (phtIdx),
        .mispredict_o (mispredict)
    );

    predictorChecker i_predictorChecker (
        .clk          (clk),
        .reset        (reset),
        .stall_i      (stall),
        .fetchOp_i    (fetchOp),
        .resolve_i    (resolve),
        .pcF_i        (pcF),
        .predTaken_i  (predTaken),
        .phtIdx_i     (phtIdx),
        .mispredict_i (mispredict),
        .errCount_o   (checkerErrors)
    );

    initial begin
        #(TotalCycles * 4 * 2);
        $display("Watchdog: the run did not finish within %0d ns", TotalCycles * 8);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic expectValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got=%h expected=%h at %0t", name, got, exp, $time);
            tbErrors++;
        end
    endtask

    function automatic resolveT makeResolve(input addrT pc, input logic isBranch,
                                            input logic isJump, input logic taken,
                                            input addrT target, input logic pred,
                                            input phtIdxT idx);
        resolveT r;
        r = '0;
        r.valid = 1'b1;
        r.pc = pc;
        r.isBranch = isBranch;
        r.isJump = isJump;
        r.taken = taken;
        r.target = target;
        r.predTaken = pred;
        r.phtIdx = idx;
        return r;
    endfunction

    // Holds a resolution for one cycle
    task automatic resolveOne(input resolveT r);
        resolve = r;
        @(negedge clk);
        resolve = '0;
    endtask

    // Wrong taken guess on the word before addr sends fetch to addr
    task automatic redirectTo(input addrT addr);
        resolveOne(makeResolve(addr - 32'd4, 1'b1, 1'b0, 1'b0, '0, 1'b1, 5'h1f));
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs = tbErrors + checkerErrors - errorsAtStart;
        testsRun++;
        if (errs == 0) begin
            $display("Test %-20s passed", name);
        end else begin
            testsFailed++;
            $display("Test %-20s failed with %0d errors", name, errs);
        end
        errorsAtStart = tbErrors + checkerErrors;
    endtask

    // Word aligned address inside a 256-byte window
    function automatic addrT randomAddr();
        logic [31:0] r;
        r = $random(seed);
        return {24'h0, r[7:2], 2'b00};
    endfunction

    function automatic opcodeT randomOp();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd6) begin
            return `OP_BRANCH;
        end else if (r[3:0] == 4'd6) begin
            return `OP_JAL;
        end else if (r[3:0] == 4'd7) begin
            return `OP_JALR;
        end
        return OpNop;
    endfunction

    // One cycle of mixed fetch, stall and resolution traffic
    task automatic randomCycle();
        logic [31:0] r;
        fetchRecT    rec;
        resolveT     res;
        logic        wrong;
        r = $random(seed);
        res = '0;
        wrong = 1'b0;
        stall = (r[2:0] == 3'd0);
        if ((inflight.size() > 2) && r[3]) begin
            rec = inflight.pop_front();
            res = makeResolve(rec.pc, rec.op == `OP_BRANCH,
                              (rec.op == `OP_JAL) || (rec.op == `OP_JALR),
                              r[4] || (rec.op != `OP_BRANCH), randomAddr(), rec.pred, rec.idx);
            wrong = (res.isBranch && (rec.pred != res.taken)) || (res.isJump && !rec.pred);
        end
        resolve = res;
        fetchOp = randomOp();
        if (wrong) begin
            inflight.delete();   // flush everything fetched after the bad guess
        end else if (!stall) begin
            rec.pc = pcF;
            rec.op = fetchOp;
            rec.pred = predTaken;
            rec.idx = phtIdx;
            inflight.push_back(rec);
        end
        @(negedge clk);
    endtask

    initial begin
        addrT prevPc;
        reset = 1'b1;
        stall = 1'b0;
        fetchOp = OpNop;
        resolve = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        expectValue("pcF_o", pcF, `PC_START);
        expectValue("predTaken_o", 32'(predTaken), 32'd0);
        expectValue("mispredict_o", 32'(mispredict), 32'd0);
        finishTest("resetState");

        for (int i = 0; i < 6; i++) begin
            prevPc = pcF;
            @(negedge clk);
            expectValue("pcF_o", pcF, prevPc + 32'd4);
        end
        stall = 1'b1;
        for (int i = 0; i < 3; i++) begin
            prevPc = pcF;
            @(negedge clk);
            expectValue("pcF_o", pcF, prevPc);
        end
        stall = 1'b0;
        finishTest("seqFetchStall");

        // Jump at 0x40 learned, 0xC0 shares its index with another tag
        resolveOne(makeResolve(32'h40, 1'b0, 1'b1, 1'b1, 32'h80, 1'b0, 5'h00));
        redirectTo(32'h40);
        expectValue("pcF_o", pcF, 32'h40);
        expectValue("predTaken_o", 32'(predTaken), 32'd1);
        @(negedge clk);
        expectValue("pcF_o", pcF, 32'h80);
        redirectTo(32'hc0);
        expectValue("predTaken_o", 32'(predTaken), 32'd0);
        finishTest("btbLearn");

        // History is zero here, so pc 0x20 uses counter 8
        resolveOne(makeResolve(32'h20, 1'b1, 1'b0, 1'b1, 32'h60, 1'b1, 5'h08));
        for (int i = 0; i < 9; i++) begin
            resolveOne(makeResolve(32'h20, 1'b1, 1'b0, TrainTaken[i], 32'h60,
                                   TrainTaken[i], 5'h08));
            redirectTo(32'h20);
            expectValue("phtIdx_o", 32'(phtIdx), 32'h08);
            expectValue("predTaken_o", 32'(predTaken), 32'(TrainPred[i]));
        end
        finishTest("counterTrain");

        // Shift a taken jump into the history, then mispredict under stall
        redirectTo(32'h40);
        fetchOp = `OP_BRANCH;
        @(negedge clk);
        fetchOp = OpNop;
        stall = 1'b1;
        resolve = makeResolve(32'h100, 1'b1, 1'b0, 1'b1, 32'h40, 1'b0, 5'h00);
        #1;
        expectValue("mispredict_o", 32'(mispredict), 32'd1);
        @(negedge clk);
        resolve = '0;
        expectValue("pcF_o", pcF, 32'h40);
        expectValue("phtIdx_o", 32'(phtIdx), 32'h10);
        stall = 1'b0;
        finishTest("mispredictRedirect");

        for (int i = 0; i < RandomCycles; i++) begin
            randomCycle();
        end
        resolve = '0;
        stall = 1'b0;
        fetchOp = OpNop;
        @(negedge clk);
        finishTest("randomRun");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 testsRun, testsFailed, tbErrors + checkerErrors);
        if ((testsFailed == 0) && (tbErrors + checkerErrors == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* fetchPredictor.f */
+incdir+include
verilog/predictorPkg.sv
verilog/targetBuffer.sv
verilog/gsharePht.sv
verilog/predictControl.sv
verilog/fetchPc.sv
verilog/fetchPredictor.sv
bench/predictorChecker.sv
bench/fetchPredictorTb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f fetchPredictor.f \
    --top-module fetchPredictorTb \
    -Mdir obj_dir -o simFetchPredictor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simFetchPredictor > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
